//--- rv_ex_top.f
hdl/rv_ex_pkg.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_ex_top.sv
tests/rv_ex_properties.sv
tests/tb_rv_ex_top.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

all: run

build:
	verilator --binary --timing --assert --top-module tb_rv_ex_top -f rv_ex_top.f

run: build
	./obj_dir/Vtb_rv_ex_top | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module tb_rv_ex_top -f rv_ex_top.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- tests/tb_rv_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_ex_top;

    import rv_ex_pkg::*;

    localparam int CLK_PERIOD  = 20;
    // reset, alu, x0 and lui, branches, jumps, back to back, invalid, tail
    localparam int TEST_CYCLES = 17 + 14 + 2 + 30 + 2 + 5 + 1 + 3;
    localparam int TIMEOUT_NS  = TEST_CYCLES * CLK_PERIOD + 500;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic      clk;
    logic      rst_i;
    logic      valid_i;
    ex_in_t    ex_in_i;
    logic      int_assert_i;
    word_t     int_addr_i;
    logic      out_valid_o;
    reg_addr_t rd_o;
    logic      wreg_o;
    word_t     wdata_o;
    logic      branch_flag_o;
    word_t     branch_addr_o;

    int    errors;
    word_t rng_state;

    rv_ex_top DUT (
        .clk           (clk),
        .rst_i         (rst_i),
        .valid_i       (valid_i),
        .ex_in_i       (ex_in_i),
        .int_assert_i  (int_assert_i),
        .int_addr_i    (int_addr_i),
        .out_valid_o   (out_valid_o),
        .rd_o          (rd_o),
        .wreg_o        (wreg_o),
        .wdata_o       (wdata_o),
        .branch_flag_o (branch_flag_o),
        .branch_addr_o (branch_addr_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t next_random();
        word_t x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // expected result from funct3 and inst[30], per the ISA
    function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // encoders, rs1 = x1 and rs2 = x2
    function automatic word_t enc_r(logic [2:0] f3, logic alt, reg_addr_t rd);
        return {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(logic [6:0] opc, logic [11:0] imm, logic [2:0] f3,
                                    reg_addr_t rd);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic word_t enc_b(logic [2:0] f3, word_t off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(word_t off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic check(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    // next rising edge, then the drive point
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic drive(word_t pc, word_t inst, word_t rs1, word_t rs2);
        valid_i      = 1'b1;
        ex_in_i.pc   = pc;
        ex_in_i.inst = inst;
        ex_in_i.rs1  = rs1;
        ex_in_i.rs2  = rs2;
        int_assert_i = 1'b0;
        int_addr_i   = '0;
    endtask

    task automatic idle();
        valid_i      = 1'b0;
        ex_in_i      = '0;
        int_assert_i = 1'b0;
    endtask

    task automatic check_strobes_low();
        check("out_valid_o", 32'd0, 32'(out_valid_o));
        check("wreg_o", 32'd0, 32'(wreg_o));
        check("branch_flag_o", 32'd0, 32'(branch_flag_o));
    endtask

    // outputs of the instruction issued one cycle earlier
    task automatic check_result(logic exp_wreg, word_t exp_wdata, logic exp_flag,
                                word_t exp_addr);
        check("out_valid_o", 32'd1, 32'(out_valid_o));
        check("wreg_o", 32'(exp_wreg), 32'(wreg_o));
        check("wdata_o", exp_wdata, wdata_o);
        check("branch_flag_o", 32'(exp_flag), 32'(branch_flag_o));
        check("branch_addr_o", exp_addr, branch_addr_o);
    endtask

    task automatic test_reset();
        rst_i = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        check_strobes_low();    // still in reset
        rst_i = 1'b0;
        step();
        check_strobes_low();
    endtask

    task automatic run_alu(logic imm_form, logic [2:0] f3, logic alt);
        word_t       a;
        word_t       b;
        word_t       r;
        word_t       rs2;
        word_t       inst;
        logic [11:0] imm;
        reg_addr_t   rd;
        a   = next_random();
        r   = next_random();
        rd  = (r[4:0] == 5'd0) ? 5'd9 : r[4:0];
        imm = r[31:20];
        if (f3 == 3'b001 || f3 == 3'b101) begin
            imm = {1'b0, alt, 5'b0, r[24:20]};    // shamt form
        end
        if (imm_form) begin
            b    = {{20{imm[11]}}, imm};
            rs2  = next_random();                  // must be ignored
            inst = enc_i(OPC_OP_IMM, imm, f3, rd);
        end else begin
            b    = next_random();
            rs2  = b;
            inst = enc_r(f3, alt, rd);
        end
        drive(next_random() & 32'hffff_fffc, inst, a, rs2);
        step();
        check("rd_o", 32'(rd), 32'(rd_o));
        check_result(1'b1, alu_model(f3, alt, a, b), 1'b0, '0);
    endtask

    task automatic test_rd_zero();
        word_t a;
        word_t b;
        a = next_random();
        b = next_random();
        drive(32'h0000_0100, enc_r(3'b000, 1'b0, 5'd0), a, b);
        step();
        check_result(1'b0, a + b, 1'b0, '0);
    endtask

    task automatic test_lui();
        word_t r;
        r = next_random();
        drive(32'h0000_0200, {r[31:12], 5'd5, OPC_LUI}, next_random(), next_random());
        step();
        check("rd_o", 32'd5, 32'(rd_o));
        check_result(1'b1, {r[31:12], 12'b0}, 1'b0, '0);
    endtask

    task automatic test_branches();
        logic [2:0] f3s [6];
        word_t      pa [5];
        word_t      pb [5];
        word_t      pc;
        word_t      off;
        word_t      r;
        logic       taken;
        f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        pa  = '{32'd5, 32'd1, 32'd2, 32'h8000_0000, 32'hffff_ffff};    // mixed signs last
        pb  = '{32'd5, 32'd2, 32'd1, 32'h0000_0001, 32'h0000_0000};
        foreach (f3s[i]) begin
            foreach (pa[j]) begin
                r   = next_random();
                pc  = next_random() & 32'hffff_fffc;
                off = {{19{r[12]}}, r[12:1], 1'b0};
                drive(pc, enc_b(f3s[i], off), pa[j], pb[j]);
                step();
                taken = branch_model(f3s[i], pa[j], pb[j]);
                check_result(1'b0, '0, taken, taken ? pc + off : '0);
            end
        end
    endtask

    task automatic test_jumps();
        word_t       pc;
        word_t       off;
        word_t       r;
        word_t       a;
        word_t       sum;
        logic [11:0] imm;
        r   = next_random();
        pc  = next_random() & 32'hffff_fffc;
        off = {{11{r[20]}}, r[20:1], 1'b0};
        drive(pc, enc_j(off, 5'd1), next_random(), next_random());
        step();
        check("rd_o", 32'd1, 32'(rd_o));
        check_result(1'b1, pc + 32'd4, 1'b1, pc + off);
        // jalr, forced odd sum
        a   = next_random();
        imm = r[31:20];
        sum = a + {{20{imm[11]}}, imm};
        if (!sum[0]) begin
            imm[0] = ~imm[0];
            sum    = a + {{20{imm[11]}}, imm};
        end
        drive(pc, enc_i(OPC_JALR, imm, 3'b000, 5'd1), a, next_random());
        step();
        check_result(1'b1, pc + 32'd4, 1'b1, {sum[31:1], 1'b0});
    endtask

    task automatic test_back_to_back();
        word_t a [4];
        word_t b [4];
        foreach (a[i]) begin
            a[i] = next_random();
            b[i] = next_random();
        end
        for (int i = 0; i < 5; i++) begin
            if (i > 0) begin
                check("rd_o", 32'(i + 9), 32'(rd_o));
                check_result(1'b1, a[i-1] + b[i-1], 1'b0, '0);
            end
            if (i < 4) begin
                drive(32'h1000 + 32'(4 * i), enc_r(3'b000, 1'b0, 5'(i + 10)), a[i], b[i]);
            end else begin
                idle();
            end
            step();
        end
    endtask

    task automatic test_interrupt();
        word_t a;
        word_t b;
        word_t iaddr;
        a     = next_random();
        b     = next_random();
        iaddr = next_random() & 32'hffff_fffc;
        drive(32'h0000_2000, enc_r(3'b000, 1'b0, 5'd4), a, b);
        int_assert_i = 1'b1;
        int_addr_i   = iaddr;
        step();
        int_assert_i = 1'b0;
        check_result(1'b0, a + b, 1'b1, iaddr);
    endtask

    task automatic test_undefined();
        word_t r;
        r = next_random();
        drive(32'h0000_3000, {r[31:7], 7'b1111111}, next_random(), next_random());
        step();
        check_result(1'b0, '0, 1'b0, '0);
    endtask

    // valid_i low, so the jal must neither write nor branch
    task automatic test_invalid();
        drive(32'h0000_4000, enc_j(32'h0000_0100, 5'd1), next_random(), next_random());
        valid_i = 1'b0;
        step();
        check_strobes_low();
        check("wdata_o", 32'd0, wdata_o);
        check("branch_addr_o", 32'd0, branch_addr_o);
    endtask

    initial begin
        errors       = 0;
        rng_state    = 32'd54;
        rst_i        = 1'b1;
        valid_i      = 1'b0;
        ex_in_i      = '0;
        int_assert_i = 1'b0;
        int_addr_i   = '0;
        test_reset();
        run_alu(1'b0, 3'b000, 1'b0);    // add
        run_alu(1'b0, 3'b000, 1'b1);    // sub
        run_alu(1'b0, 3'b111, 1'b0);
        run_alu(1'b0, 3'b110, 1'b0);
        run_alu(1'b0, 3'b100, 1'b0);
        run_alu(1'b0, 3'b010, 1'b0);    // slt
        run_alu(1'b0, 3'b011, 1'b0);
        run_alu(1'b0, 3'b001, 1'b0);
        run_alu(1'b0, 3'b101, 1'b0);    // srl
        run_alu(1'b0, 3'b101, 1'b1);    // sra
        run_alu(1'b1, 3'b000, 1'b0);    // addi
        run_alu(1'b1, 3'b100, 1'b0);
        run_alu(1'b1, 3'b010, 1'b0);
        run_alu(1'b1, 3'b101, 1'b1);    // srai
        test_rd_zero();
        test_lui();
        test_branches();
        test_jumps();
        test_back_to_back();
        test_interrupt();
        test_undefined();
        test_invalid();
        idle();
        step();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/rv_ex_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ex_properties (
    input wire logic             clk,
    input wire logic             rst_i,
    input wire logic             int_assert_i,
    input wire rv_ex_pkg::word_t int_addr_i,
    input wire logic             out_valid_i,
    input wire logic             wreg_i,
    input wire logic             branch_flag_i,
    input wire rv_ex_pkg::word_t branch_addr_i
);

    // strobes come out of reset low
    reset_clears: assert property (@(posedge clk)
        rst_i |=> !out_valid_i && !wreg_i && !branch_flag_i)
        else $error("strobes not low one cycle after reset");

    wreg_needs_valid: assert property (@(posedge clk) disable iff (rst_i)
        wreg_i |-> out_valid_i)
        else $error("register write without a valid output");

    // interrupt takes the branch and blocks the write
    int_override: assert property (@(posedge clk) disable iff (rst_i)
        int_assert_i |=> branch_flag_i && !wreg_i && (branch_addr_i == $past(int_addr_i)))
        else $error("interrupt override not applied");

endmodule

bind rv_ex_top rv_ex_properties u_properties (
    .clk           (clk),
    .rst_i         (rst_i),
    .int_assert_i  (int_assert_i),
    .int_addr_i    (int_addr_i),
    .out_valid_i   (out_valid_o),
    .wreg_i        (wreg_o),
    .branch_flag_i (branch_flag_o),
    .branch_addr_i (branch_addr_o)
);

`default_nettype wire

//--- hdl/rv_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ex_top (
    input  wire logic                 clk,
    input  wire logic                 rst_i,
    input  wire logic                 valid_i,
    input  wire rv_ex_pkg::ex_in_t    ex_in_i,
    input  wire logic                 int_assert_i,
    input  wire rv_ex_pkg::word_t     int_addr_i,
    output logic                      out_valid_o,
    output rv_ex_pkg::reg_addr_t      rd_o,
    output logic                      wreg_o,
    output rv_ex_pkg::word_t          wdata_o,
    output logic                      branch_flag_o,
    output rv_ex_pkg::word_t          branch_addr_o
);

    import rv_ex_pkg::*;

    dec_t      dec;
    unit_res_t res;

    rv_decode u_decode (
        .ex_in_i (ex_in_i),
        .valid_i (valid_i),
        .dec_o   (dec)
    );

    // combinational units, same cycle as decode
    rv_execute u_execute (
        .dec_i (dec),
        .pc_i  (ex_in_i.pc),
        .res_o (res)
    );

    rv_result u_result (
        .clk           (clk),
        .rst_i         (rst_i),
        .valid_i       (valid_i),
        .sel_i         (dec.sel),
        .rd_i          (dec.rd),
        .wreg_i        (dec.wreg),
        .res_i         (res),
        .int_assert_i  (int_assert_i),
        .int_addr_i    (int_addr_i),
        .out_valid_o   (out_valid_o),
        .rd_o          (rd_o),
        .wreg_o        (wreg_o),
        .wdata_o       (wdata_o),
        .branch_flag_o (branch_flag_o),
        .branch_addr_o (branch_addr_o)
    );

endmodule

`default_nettype wire

//--- hdl/rv_result.sv
`timescale 1ns/1ps
`default_nettype none

module rv_result (
    input  wire logic                 clk,
    input  wire logic                 rst_i,
    input  wire logic                 valid_i,
    input  wire rv_ex_pkg::res_sel_e  sel_i,
    input  wire rv_ex_pkg::reg_addr_t rd_i,
    input  wire logic                 wreg_i,
    input  wire rv_ex_pkg::unit_res_t res_i,
    input  wire logic                 int_assert_i,
    input  wire rv_ex_pkg::word_t     int_addr_i,
    output logic                      out_valid_o,
    output rv_ex_pkg::reg_addr_t      rd_o,
    output logic                      wreg_o,
    output rv_ex_pkg::word_t          wdata_o,
    output logic                      branch_flag_o,
    output rv_ex_pkg::word_t          branch_addr_o
);

    import rv_ex_pkg::*;

    word_t wdata;

    always_comb begin
        case (sel_i)
            RES_LOGIC:   wdata = res_i.logicout;
            RES_COMPARE: wdata = res_i.compare;
            RES_SHIFT:   wdata = res_i.shiftres;
            RES_ARITH:   wdata = res_i.arith;
            RES_BRANCH:  wdata = res_i.link;    // jal / jalr link
            default:     wdata = '0;
        endcase
    end

    // pipeline register, interrupt wins over the instruction
    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_o   <= 1'b0;
            rd_o          <= '0;
            wreg_o        <= 1'b0;
            wdata_o       <= '0;
            branch_flag_o <= 1'b0;
            branch_addr_o <= '0;
        end else begin
            out_valid_o   <= valid_i;
            rd_o          <= rd_i;
            wreg_o        <= wreg_i && !int_assert_i;
            wdata_o       <= wdata;
            branch_flag_o <= res_i.branch_flag || int_assert_i;
            branch_addr_o <= int_assert_i ? int_addr_i : res_i.branch_addr;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  wire rv_ex_pkg::dec_t   dec_i,
    input  wire rv_ex_pkg::word_t  pc_i,
    output rv_ex_pkg::unit_res_t   res_o
);

    import rv_ex_pkg::*;

    word_t a;
    word_t b;
    word_t sum;
    word_t diff;
    word_t jalr_sum;
    word_t target;
    logic  eq;
    logic  lt_s;
    logic  lt_u;
    logic  taken;

    assign a    = dec_i.a;
    assign b    = dec_i.b;
    assign sum  = a + b;
    assign diff = a - b;

    // shared by slt/sltu and the branches
    assign eq   = (a == b);
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    // jalr drops bit 0 of the sum
    assign jalr_sum = a + dec_i.imm;

    always_comb begin
        if (dec_i.op == ALU_JALR) begin
            target = {jalr_sum[XLEN-1:1], 1'b0};
        end else begin
            target = pc_i + dec_i.imm;    // b-type and jal
        end
    end

    // the one branch decision of the stage
    always_comb begin
        case (dec_i.op)
            ALU_BEQ:  taken = eq;
            ALU_BNE:  taken = !eq;
            ALU_BLT:  taken = lt_s;
            ALU_BGE:  taken = !lt_s;
            ALU_BLTU: taken = lt_u;
            ALU_BGEU: taken = !lt_u;
            ALU_JAL,
            ALU_JALR: taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        res_o             = '0;
        res_o.link        = pc_i + 32'd4;
        res_o.branch_flag = taken;
        res_o.branch_addr = taken ? target : '0;
        case (dec_i.op)
            ALU_ADD:  res_o.arith    = sum;
            ALU_SUB:  res_o.arith    = diff;
            ALU_AND:  res_o.logicout = a & b;
            ALU_OR:   res_o.logicout = a | b;
            ALU_XOR:  res_o.logicout = a ^ b;
            ALU_SLT:  res_o.compare  = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: res_o.compare  = {{(XLEN-1){1'b0}}, lt_u};
            ALU_SLL:  res_o.shiftres = a << b[4:0];
            ALU_SRL:  res_o.shiftres = a >> b[4:0];
            ALU_SRA:  res_o.shiftres = $signed(a) >>> b[4:0];    // sign fill
            ALU_LUI:  res_o.shiftres = b;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire rv_ex_pkg::ex_in_t ex_in_i,
    input  wire logic              valid_i,
    output rv_ex_pkg::dec_t        dec_o
);

    import rv_ex_pkg::*;

    word_t      inst;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;        // inst[30], sub / sra select
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    alu_op_e    op;
    res_sel_e   sel;
    logic       writes;
    word_t      b;
    word_t      imm;

    assign inst   = ex_in_i.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign alt    = inst[30];
    assign rd     = inst[11:7];

    // immediate formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        op     = ALU_NONE;
        sel    = RES_NONE;
        writes = 1'b0;
        b      = ex_in_i.rs2;
        imm    = imm_i;
        case (opcode)
            OP, OP_IMM: begin
                writes = 1'b1;
                if (opcode == OP_IMM) begin
                    b = imm_i;
                end
                case (funct3)
                    3'b000: begin
                        op  = (opcode == OP && alt) ? ALU_SUB : ALU_ADD;    // no subi
                        sel = RES_ARITH;
                    end
                    3'b001: begin
                        op  = ALU_SLL;
                        sel = RES_SHIFT;
                    end
                    3'b010: begin
                        op  = ALU_SLT;
                        sel = RES_COMPARE;
                    end
                    3'b011: begin
                        op  = ALU_SLTU;
                        sel = RES_COMPARE;
                    end
                    3'b100: begin
                        op  = ALU_XOR;
                        sel = RES_LOGIC;
                    end
                    3'b101: begin
                        op  = alt ? ALU_SRA : ALU_SRL;
                        sel = RES_SHIFT;
                    end
                    3'b110: begin
                        op  = ALU_OR;
                        sel = RES_LOGIC;
                    end
                    default: begin
                        op  = ALU_AND;
                        sel = RES_LOGIC;
                    end
                endcase
            end
            LUI: begin
                op     = ALU_LUI;
                sel    = RES_SHIFT;    // passes b through the shift unit
                writes = 1'b1;
                b      = imm_u;
            end
            BRANCH: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  op = ALU_BEQ;
                    3'b001:  op = ALU_BNE;
                    3'b100:  op = ALU_BLT;
                    3'b101:  op = ALU_BGE;
                    3'b110:  op = ALU_BLTU;
                    3'b111:  op = ALU_BGEU;
                    default: op = ALU_NONE;
                endcase
            end
            JAL: begin
                op     = ALU_JAL;
                sel    = RES_BRANCH;
                writes = 1'b1;
                imm    = imm_j;
            end
            JALR: begin
                op     = ALU_JALR;
                sel    = RES_BRANCH;
                writes = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        dec_o.op   = valid_i ? op : ALU_NONE;
        dec_o.sel  = valid_i ? sel : RES_NONE;
        dec_o.rd   = rd;
        dec_o.wreg = valid_i && writes && (rd != '0);    // x0 is never written
        dec_o.a    = ex_in_i.rs1;
        dec_o.b    = b;
        dec_o.imm  = imm;
    end

endmodule

`default_nettype wire

//--- hdl/rv_ex_pkg.sv
`default_nettype none

package rv_ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_JAL,
        ALU_JALR
    } alu_op_e;

    // which unit feeds the write-back word
    typedef enum logic [2:0] {
        RES_NONE,
        RES_LOGIC,
        RES_COMPARE,
        RES_SHIFT,
        RES_ARITH,
        RES_BRANCH
    } res_sel_e;

    typedef struct packed {
        word_t pc;
        word_t inst;
        word_t rs1;
        word_t rs2;
    } ex_in_t;

    typedef struct packed {
        alu_op_e   op;
        res_sel_e  sel;
        reg_addr_t rd;
        logic      wreg;
        word_t     a;
        word_t     b;      // rs2 or I/U immediate
        word_t     imm;    // target offset
    } dec_t;

    typedef struct packed {
        word_t logicout;
        word_t compare;
        word_t shiftres;
        word_t arith;
        word_t link;
        logic  branch_flag;
        word_t branch_addr;
    } unit_res_t;

endpackage

`default_nettype wire
